// File: include/vmask_settings.svh
// width settings of the vector mask unit, included by the package and the testbench
`ifndef VMASK_SETTINGS_SVH
`define VMASK_SETTINGS_SVH

// vector register length in bits
// one mask bit per byte element, so the mask is VLEN/8 wide
`define VMASK_VLEN 128

// operation code width
// five legal codes, 0 to 4, the rest are illegal
`define VMASK_OP_W 3

`endif

// File: logic/vmask_pkg.sv
// types and operation codes shared by every block of the vector mask unit and its testbench
`default_nettype none

`include "vmask_settings.svh"

package vmask_pkg;

    // mask register, one bit per element
    typedef logic [(`VMASK_VLEN/8)-1:0] mask_t;

    // scalar or vector result word
    typedef logic [63:0] bus64_t;

    // mask operation code
    typedef logic [`VMASK_OP_W-1:0] vmask_op_t;

    // element count, must hold 0 up to the full mask width
    typedef logic [$clog2(`VMASK_VLEN/8):0] cnt_t;

    // element index inside the mask
    typedef logic [$clog2(`VMASK_VLEN/8)-1:0] idx_t;

    // operation codes
    localparam vmask_op_t OP_VMSBF  = vmask_op_t'(0);  // set before first
    localparam vmask_op_t OP_VMSIF  = vmask_op_t'(1);  // set including first
    localparam vmask_op_t OP_VMSOF  = vmask_op_t'(2);  // set only first
    localparam vmask_op_t OP_VCPOP  = vmask_op_t'(3);  // population count
    localparam vmask_op_t OP_VFIRST = vmask_op_t'(4);  // find first set
    // codes 5 to 7 are reserved

endpackage

`default_nettype wire

// File: logic/vmask_op_if.sv
// one registered mask instruction, driven by the issue stage and read by the execute blocks
`default_nettype none

interface vmask_op_if;
    import vmask_pkg::*;

    logic      valid;     // instruction present this cycle
    vmask_op_t op;        // operation code
    mask_t     vs2;       // source mask operand
    mask_t     vm;        // mask operand v0
    logic      use_mask;  // masked form of the instruction
    mask_t     active;    // precomputed active elements

    // register stage drives everything
    modport issue (
        output valid, op, vs2, vm, use_mask, active
    );

    // execute and writeback only look
    modport exec (
        input valid, op, vs2, vm, use_mask, active
    );

endinterface

`default_nettype wire

// File: logic/vmsbf.sv
// set-before-first, set-including-first and set-only-first over the active elements of vs2
`default_nettype none

module vmsbf (
    vmask_op_if.exec       op_i,   // registered instruction
    output vmask_pkg::mask_t set_o // set-first result, zero for other ops
);
    import vmask_pkg::*;

    logic  is_set_op;              // one of the three set-first forms
    mask_t hit;                    // active and set in vs2
    logic  [$bits(mask_t):0] none; // none[i]: no hit below element i
    mask_t bf;                     // before first
    mask_t sif;                    // including first
    mask_t sof;                    // only first

    assign is_set_op = (op_i.op == OP_VMSBF) ||
                       (op_i.op == OP_VMSIF) ||
                       (op_i.op == OP_VMSOF);

    // hold operands at zero for other ops, keeps the chain quiet
    assign hit = is_set_op ? (op_i.vs2 & op_i.active) : '0;

    always_comb begin
        none[0] = 1'b1;                     // nothing seen before element 0
        for (int i = 0; i < $bits(mask_t); i++) begin
            none[i+1] = none[i] & ~hit[i]; // inactive bits never clear it
        end
    end

    // all three forms tap the same ripple chain
    always_comb begin
        for (int i = 0; i < $bits(mask_t); i++) begin
            bf[i]  = none[i+1];           // no hit at 0..i
            sif[i] = none[i];             // no hit at 0..i-1
            sof[i] = none[i] & hit[i];    // the lowest hit only
        end
    end

    always_comb begin
        unique case (op_i.op)
            OP_VMSBF: set_o = bf;
            OP_VMSIF: set_o = sif;
            OP_VMSOF: set_o = sof;
            default:  set_o = '0;         // counts and illegal codes
        endcase
    end

endmodule

`default_nettype wire

// File: logic/vmask_count.sv
// population count and find-first-set over the active set bits of vs2
`default_nettype none

module vmask_count (
    vmask_op_if.exec          op_i,    // registered instruction
    output vmask_pkg::cnt_t   cpop_o,  // number of active set bits
    output vmask_pkg::idx_t   first_o, // lowest active set index
    output logic              found_o  // at least one active set bit
);
    import vmask_pkg::*;

    logic  is_cnt_op; // vcpop or vfirst
    mask_t hit;       // active and set, gated

    assign is_cnt_op = (op_i.op == OP_VCPOP) || (op_i.op == OP_VFIRST);

    // zero operands for other ops, adder tree stays still
    assign hit = is_cnt_op ? (op_i.vs2 & op_i.active) : '0;

    // plain adder over the mask bits
    always_comb begin
        cpop_o = '0;
        for (int i = 0; i < $bits(mask_t); i++) begin
            cpop_o = cpop_o + cnt_t'(hit[i]);
        end
    end

    // scan downward so the lowest hit wins
    always_comb begin
        first_o = '0;                   // don't care when nothing found
        for (int i = $bits(mask_t) - 1; i >= 0; i--) begin
            if (hit[i]) begin
                first_o = idx_t'(i);
            end
        end
    end

    assign found_o = |hit;

endmodule

`default_nettype wire

// File: logic/vmask_issue.sv
// input register stage of the mask unit, captures one instruction per cycle onto the interface
`default_nettype none

module vmask_issue (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,    // instruction strobe
    input  vmask_pkg::vmask_op_t  op_i,       // operation code
    input  vmask_pkg::mask_t      vs2_i,      // source mask
    input  vmask_pkg::mask_t      vm_i,       // mask operand
    input  logic                  use_mask_i, // masked instruction
    vmask_op_if.issue             op_o        // registered instruction
);
    import vmask_pkg::*;

    mask_t active_d; // active elements of the incoming instruction

    // unmasked form treats every element as active
    assign active_d = use_mask_i ? vm_i : '1;

    // valid follows the strobe, no hold
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_o.valid <= 1'b0;
        end else begin
            op_o.valid <= valid_i;
        end
    end

    // op code and mask form, loaded with the strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_o.op       <= OP_VMSBF;
            op_o.use_mask <= 1'b0;
        end else if (valid_i) begin
            op_o.op       <= op_i;
            op_o.use_mask <= use_mask_i;
        end
    end

    // operands load only on valid, idle cycles keep them still
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o.vs2    <= vs2_i;
            op_o.vm     <= vm_i;
            op_o.active <= active_d; // mask applied once, here
        end
    end

endmodule

`default_nettype wire

// File: logic/vmask_wb.sv
// writeback stage of the mask unit, selects the result by op and registers it with its valid
`default_nettype none

module vmask_wb (
    input  logic              clk_i,
    input  logic              arst_n_i,
    vmask_op_if.exec          op_i,     // registered instruction
    input  vmask_pkg::mask_t  set_i,    // set-first result
    input  vmask_pkg::cnt_t   cpop_i,   // population count
    input  vmask_pkg::idx_t   first_i,  // lowest active set index
    input  logic              found_i,  // any active set bit
    output logic              valid_o,  // result strobe
    output vmask_pkg::bus64_t result_o  // result word
);
    import vmask_pkg::*;

    bus64_t result_d; // selected result
    logic   legal;    // known op code

    always_comb begin
        legal    = 1'b1;
        result_d = '0;
        unique case (op_i.op)
            OP_VMSBF, OP_VMSIF, OP_VMSOF: result_d = bus64_t'(set_i);
            OP_VCPOP:  result_d = bus64_t'(cpop_i);
            OP_VFIRST: result_d = found_i ? bus64_t'(first_i) : '1; // -1 when none
            default:   legal    = 1'b0;  // codes 5 to 7 dropped
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= op_i.valid & legal;
            if (op_i.valid && legal) begin
                result_o <= result_d;  // hold last result when idle
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/vmask_unit.sv
// top of the vector mask unit, issue register, set-first and count blocks, then writeback
`default_nettype none

module vmask_unit (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,    // instruction strobe
    input  vmask_pkg::vmask_op_t  op_i,       // operation code
    input  vmask_pkg::mask_t      vs2_i,      // source mask
    input  vmask_pkg::mask_t      vm_i,       // mask operand
    input  logic                  use_mask_i, // masked instruction
    output logic                  valid_o,    // result strobe, two edges later
    output vmask_pkg::bus64_t     result_o    // result word
);
    import vmask_pkg::*;

    mask_t set;   // set-first result
    cnt_t  cpop;  // active set bit count
    idx_t  first; // lowest active set index
    logic  found; // any active set bit

    vmask_op_if op_if ();

    vmask_issue u_issue (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .vs2_i      (vs2_i),
        .vm_i       (vm_i),
        .use_mask_i (use_mask_i),
        .op_o       (op_if.issue)
    );

    vmsbf u_vmsbf (
        .op_i  (op_if.exec),
        .set_o (set)
    );

    vmask_count u_count (
        .op_i    (op_if.exec),
        .cpop_o  (cpop),
        .first_o (first),
        .found_o (found)
    );

    vmask_wb u_wb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .op_i     (op_if.exec),
        .set_i    (set),
        .cpop_i   (cpop),
        .first_i  (first),
        .found_i  (found),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

// File: tests/vmask_asserts.sv
// concurrent checks on the mask unit ports, attached to vmask_unit with bind from the testbench
`default_nettype none

module vmask_asserts (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 valid_i,
    input vmask_pkg::vmask_op_t op_i,
    input logic                 valid_o,
    input vmask_pkg::bus64_t    result_o
);
    import vmask_pkg::*;

    logic legal_in;   // strobe with a known code
    logic set_in;     // strobe with a set-first code
    int   n_fail = 0; // assertion failures so far

    assign legal_in = valid_i && (op_i inside {OP_VMSBF, OP_VMSIF, OP_VMSOF, OP_VCPOP, OP_VFIRST});
    assign set_in   = valid_i && (op_i inside {OP_VMSBF, OP_VMSIF, OP_VMSOF});

    // quiet in reset and on the first edge after release
    a_reset_quiet: assert property (
        @(posedge clk_i) (!arst_n_i || $rose(arst_n_i)) |-> !valid_o
    ) else begin
        n_fail++;
        $error("valid_o high during or right after reset");
    end

    // fixed latency of two edges, illegal codes give no strobe
    a_latency: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_o == $past(legal_in, 2)
    ) else begin
        n_fail++;
        $error("valid_o does not follow a legal valid_i two edges later");
    end

    // set-first words fit the mask width
    a_set_width: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        set_in |=> ##1 (result_o[63:$bits(mask_t)] == '0)
    ) else begin
        n_fail++;
        $error("set-first result wider than the mask");
    end

endmodule

`default_nettype wire

// File: tests/vmask_tb.sv
// self-checking testbench of the vector mask unit, random mask instructions checked against a model
`default_nettype none

`include "vmask_settings.svh"

module vmask_tb;
    import vmask_pkg::*;

    localparam int MASK_W   = `VMASK_VLEN / 8;  // elements per mask
    localparam int PERIOD   = 4;
    localparam int RST_CYC  = 10;
    localparam int N_IDLE   = 5;                 // quiet cycles after reset
    localparam int N_SET    = 300;
    localparam int N_CPOP   = 150;
    localparam int N_FIRST  = 150;
    localparam int N_MIX    = 300;
    localparam int STIM_CYC = N_IDLE + N_SET + N_CPOP + N_FIRST + N_MIX;
    localparam int TIMEOUT  = (RST_CYC + STIM_CYC + 20) * PERIOD;

    logic      clk_i;
    logic      arst_n_i;
    logic      valid_i;
    vmask_op_t op_i;
    mask_t     vs2_i;
    mask_t     vm_i;
    logic      use_mask_i;
    logic      valid_o;
    bus64_t    result_o;

    logic [31:0] rng_state;   // lcg state
    int          cyc;         // falling edges so far
    int          n_checks;
    int          n_errors;
    logic        seen_result; // a result has come out
    bus64_t      exp_q[$];    // expected words, issue order
    int          due_q[$];    // falling edge each word is due

    vmask_unit uut (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .vs2_i      (vs2_i),
        .vm_i       (vm_i),
        .use_mask_i (use_mask_i),
        .valid_o    (valid_o),
        .result_o   (result_o)
    );

    bind vmask_unit vmask_asserts u_asserts (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // numerical recipes lcg
        return rng_state;
    endfunction

    function automatic mask_t rand_mask();
        logic [31:0] r;
        r = rand_next();
        return mask_t'(r >> 16); // upper bits, low ones cycle fast
    endfunction

    // expected word straight from the instruction rules
    function automatic bus64_t model_word(vmask_op_t op, mask_t vs2, mask_t vm, logic use_mask);
        mask_t  act;
        int     first;  // -1 when no active set bit
        int     count;
        bus64_t word;
        act   = use_mask ? vm : {MASK_W{1'b1}};
        first = -1;
        count = 0;
        for (int i = 0; i < MASK_W; i++) begin
            if (act[i] && vs2[i]) begin
                count++;
                if (first < 0) begin
                    first = i;
                end
            end
        end
        word = '0;
        for (int i = 0; i < MASK_W; i++) begin
            case (op)
                OP_VMSBF: word[i] = (first < 0) || (i < first);
                OP_VMSIF: word[i] = (first < 0) || (i <= first);
                OP_VMSOF: word[i] = (i == first);
                default:  word[i] = 1'b0;
            endcase
        end
        if (op == OP_VCPOP) begin
            word = bus64_t'(count);
        end
        if (op == OP_VFIRST) begin
            word = (first < 0) ? '1 : bus64_t'(first); // all ones when none
        end
        return word;
    endfunction

    task automatic compare_word(string name, bus64_t exp, bus64_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            compare_bit("valid_o", 1'b1, valid_o);
            compare_word("result_o", exp_q[0], result_o);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            seen_result = 1'b1;
        end else begin
            compare_bit("valid_o", 1'b0, valid_o); // nothing due this cycle
            if (!seen_result) begin
                compare_word("result_o", '0, result_o); // still the reset value
            end
        end
    endtask

    // one falling edge: check outputs, then drive the next instruction
    task automatic issue(vmask_op_t op, mask_t vs2, mask_t vm, logic use_mask, logic valid);
        @(negedge clk_i);
        cyc++;
        check_outputs();
        valid_i    = valid;
        op_i       = op;
        vs2_i      = vs2;
        vm_i       = vm;
        use_mask_i = use_mask;
        if (valid && op <= OP_VFIRST) begin // illegal codes expect nothing
            exp_q.push_back(model_word(op, vs2, vm, use_mask));
            due_q.push_back(cyc + 2);
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] r;
        r = rand_next();
        issue(vmask_op_t'(r >> 29), rand_mask(), rand_mask(), r[28], 1'b0);
    endtask

    task automatic finish_test(string name, int err_before);
        while (exp_q.size() != 0) begin
            idle_cycle(); // drain whatever is in flight
        end
        $display("test %s done, %0d errors", name, n_errors - err_before);
    endtask

    // random set-first ops, first six are all-zero vs2 and a lone bit 15
    task automatic run_set_first();
        int          err0;
        logic [31:0] r;
        mask_t       vs2;
        vmask_op_t   op;
        err0 = n_errors;
        for (int i = 0; i < N_SET; i++) begin
            r   = rand_next();
            op  = vmask_op_t'((r >> 16) % 3);
            vs2 = rand_mask();
            if (i < 3) begin
                op  = vmask_op_t'(i);
                vs2 = '0;
            end else if (i < 6) begin
                op  = vmask_op_t'(i - 3);
                vs2 = mask_t'(1) << (MASK_W - 1);
            end
            issue(op, vs2, rand_mask(), (i < 6) ? 1'b0 : r[31],
                  (i < 6) || (r[30:29] != 2'b00)); // corner cases always issued
        end
        finish_test("set_first", err0);
    endtask

    task automatic run_count(vmask_op_t op, string name, int n);
        int          err0;
        logic [31:0] r;
        mask_t       vs2;
        mask_t       vm;
        err0 = n_errors;
        for (int i = 0; i < n; i++) begin
            r   = rand_next();
            vs2 = (i == 0) ? '1 : rand_mask(); // full count, unmasked
            vm  = (i == 1) ? '0 : rand_mask(); // every set bit masked off
            issue(op, vs2, vm, (i == 1) ? 1'b1 : (i == 0) ? 1'b0 : r[31], 1'b1);
        end
        finish_test(name, err0);
    endtask

    // back to back, all eight codes
    task automatic run_mixed();
        int          err0;
        logic [31:0] r;
        err0 = n_errors;
        for (int i = 0; i < N_MIX; i++) begin
            r = rand_next();
            issue(vmask_op_t'(r >> 29), rand_mask(), rand_mask(), r[28], 1'b1);
        end
        finish_test("mixed", err0);
    endtask

    initial begin
        rng_state   = 32'd26624;
        cyc         = 0;
        n_checks    = 0;
        n_errors    = 0;
        seen_result = 1'b0;
        arst_n_i    = 1'b0;
        valid_i     = 1'b0;
        op_i        = '0;
        vs2_i       = '0;
        vm_i        = '0;
        use_mask_i  = 1'b0;
        repeat (RST_CYC) idle_cycle();
        arst_n_i = 1'b1; // released on a falling edge
        repeat (N_IDLE) idle_cycle();
        $display("test reset done, %0d errors", n_errors);
        run_set_first();
        run_count(OP_VCPOP, "vcpop", N_CPOP);
        run_count(OP_VFIRST, "vfirst", N_FIRST);
        run_mixed();
        n_errors += uut.u_asserts.n_fail; // concurrent property failures
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout, the run did not end within %0d time units", TIMEOUT);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
logic/vmask_pkg.sv
logic/vmask_op_if.sv
logic/vmsbf.sv
logic/vmask_count.sv
logic/vmask_issue.sv
logic/vmask_wb.sv
logic/vmask_unit.sv
tests/vmask_asserts.sv
tests/vmask_tb.sv

// File: Bender.yml
package:
  name: vmask_unit

export_include_dirs:
  - include

sources:
  - logic/vmask_pkg.sv
  - logic/vmask_op_if.sv
  - logic/vmsbf.sv
  - logic/vmask_count.sv
  - logic/vmask_issue.sv
  - logic/vmask_wb.sv
  - logic/vmask_unit.sv
  - target: test
    files:
      - tests/vmask_asserts.sv
      - tests/vmask_tb.sv
